/* verilog/vec_isa_pkg.sv */
// Integer subset only. Elements are 32-bit and wrap, with no masking and no memory access
`default_nettype none

package vec_isa_pkg;

  //////////////////////////////////////////////////////////////////////
  // Architectural sizes
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ElemWidth    = 32;
  localparam int unsigned NrVRegs      = 8;
  localparam int unsigned VRegIdxWidth = 3;
  localparam int unsigned IdWidth      = 4;

  // Any encoding not listed here is answered with an error response
  typedef enum logic [3:0] {
    VMV_VX     = 4'd0,
    VID_V      = 4'd1,
    VADD_VV    = 4'd2,
    VSUB_VV    = 4'd3,
    VAND_VV    = 4'd4,
    VOR_VV     = 4'd5,
    VXOR_VV    = 4'd6,
    VADD_VX    = 4'd7,
    VREDSUM_VS = 4'd8
  } vec_opcode_e;

  // Host request
  // Binary ops compute vs2 op vs1, and vredsum sums vs2 seeded with rs1
  typedef struct packed {
    vec_opcode_e             opcode;
    logic [VRegIdxWidth-1:0] vd;
    logic [VRegIdxWidth-1:0] vs1;
    logic [VRegIdxWidth-1:0] vs2;
    logic [ElemWidth-1:0]    rs1;
    logic [IdWidth-1:0]      id;
  } vec_req_t;

  // Response to the host
  // Data is zero unless the request was a reduction
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic                 error;
    logic [ElemWidth-1:0] data;
  } vec_resp_t;

endpackage : vec_isa_pkg

`default_nettype wire

/* verilog/vec_uarch_pkg.sv */
// Lane-side encodings. All lanes execute the same command in lockstep
`default_nettype none

package vec_uarch_pkg;

  // Element-wise operation performed by every lane
  typedef enum logic [2:0] {
    LANE_SPLAT,
    LANE_INDEX,
    LANE_ADD,
    LANE_SUB,
    LANE_AND,
    LANE_OR,
    LANE_XOR,
    LANE_SUM
  } lane_op_e;

  // Command broadcast to the lanes on the start pulse
  typedef struct packed {
    lane_op_e                                op;
    logic [vec_isa_pkg::VRegIdxWidth-1:0]    vd;
    logic [vec_isa_pkg::VRegIdxWidth-1:0]    vs1;
    logic [vec_isa_pkg::VRegIdxWidth-1:0]    vs2;
    logic                                    use_scalar;
    logic [vec_isa_pkg::ElemWidth-1:0]       scalar;
  } lane_cmd_t;

  // Bookkeeping for the instruction whose response is pending
  typedef struct packed {
    logic [vec_isa_pkg::IdWidth-1:0]   id;
    logic                              error;
    logic                              is_reduction;
    logic [vec_isa_pkg::ElemWidth-1:0] seed;
  } result_tag_t;

endpackage : vec_uarch_pkg

`default_nettype wire

/* verilog/vec_queue.sv */
// Depth must be at least 1. Output data is undefined while valid_o is low
`timescale 1ns/10ps
`default_nettype none

module vec_queue #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 2
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Write side
  input  payload_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  // Read side
  output payload_t data_o,
  output logic     valid_o,
  input  logic     ready_i
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  payload_t            mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push;
  logic                pop;

  // Wrap at Depth, which need not be a power of two
  function automatic logic [PtrWidth-1:0] ptr_next(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign ready_o = (count_q != CntWidth'(Depth));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // A write that meets a full queue is held until the queue has room
  a_stall_holds : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_i && !ready_o) |=> (valid_i && $stable(data_i)))
    else $error("vec_queue: write dropped or changed while the queue was full");

endmodule : vec_queue

`default_nettype wire

/* verilog/vec_dispatcher.sv */
// Issues one lane instruction at a time. Illegal opcodes skip the lanes and touch no register
`timescale 1ns/10ps
`default_nettype none

module vec_dispatcher (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // From the request queue
  input  vec_isa_pkg::vec_req_t      req_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  // To the lanes
  output vec_uarch_pkg::lane_cmd_t   lane_cmd_o,
  output logic                       lane_cmd_valid_o,
  input  logic                       lane_done_i,
  // To the result unit
  output vec_uarch_pkg::result_tag_t tag_o,
  output logic                       tag_valid_o,
  input  logic                       tag_ready_i
);

  vec_uarch_pkg::lane_op_e op;
  logic                    use_scalar;
  logic                    is_reduction;
  logic                    illegal;
  logic                    can_issue;
  logic                    lane_busy_q;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    op      = vec_uarch_pkg::LANE_ADD;
    illegal = 1'b0;
    case (req_i.opcode)
      vec_isa_pkg::VMV_VX:     op = vec_uarch_pkg::LANE_SPLAT;
      vec_isa_pkg::VID_V:      op = vec_uarch_pkg::LANE_INDEX;
      vec_isa_pkg::VADD_VV,
      vec_isa_pkg::VADD_VX:    op = vec_uarch_pkg::LANE_ADD;
      vec_isa_pkg::VSUB_VV:    op = vec_uarch_pkg::LANE_SUB;
      vec_isa_pkg::VAND_VV:    op = vec_uarch_pkg::LANE_AND;
      vec_isa_pkg::VOR_VV:     op = vec_uarch_pkg::LANE_OR;
      vec_isa_pkg::VXOR_VV:    op = vec_uarch_pkg::LANE_XOR;
      vec_isa_pkg::VREDSUM_VS: op = vec_uarch_pkg::LANE_SUM;
      default:                 illegal = 1'b1;
    endcase
  end

  // Scalar operand replaces vs1
  assign use_scalar   = (req_i.opcode == vec_isa_pkg::VMV_VX) ||
                        (req_i.opcode == vec_isa_pkg::VADD_VX);
  assign is_reduction = (req_i.opcode == vec_isa_pkg::VREDSUM_VS);

  assign lane_cmd_o = '{
    op:         op,
    vd:         req_i.vd,
    vs1:        req_i.vs1,
    vs2:        req_i.vs2,
    use_scalar: use_scalar,
    scalar:     req_i.rs1
  };

  assign tag_o = '{
    id:           req_i.id,
    error:        illegal,
    is_reduction: is_reduction,
    seed:         req_i.rs1
  };

  //////////////////////////////////////////////////////////////////////
  // Issue
  //////////////////////////////////////////////////////////////////////

  // Error tags need only a free result slot
  assign can_issue        = illegal || !lane_busy_q;
  assign tag_valid_o      = req_valid_i && can_issue;
  assign req_ready_o      = tag_ready_i && can_issue;
  assign lane_cmd_valid_o = tag_valid_o && tag_ready_i && !illegal;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lane_busy_q <= 1'b0;
    end else if (lane_cmd_valid_o) begin
      lane_busy_q <= 1'b1;
    end else if (lane_done_i) begin
      lane_busy_q <= 1'b0;
    end
  end

  // Lane completion only ends an issued instruction and never meets a new start
  a_done_when_busy : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lane_done_i |-> lane_busy_q && !lane_cmd_valid_o)
    else $error("vec_dispatcher: lane_done without a running instruction");

endmodule : vec_dispatcher

`default_nettype wire

/* verilog/vec_lane.sv */
// Register slice has no reset, so a register must be written before it is read
`timescale 1ns/10ps
`default_nettype none

module vec_lane #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 2,
  parameter int unsigned LaneId       = 0
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  vec_uarch_pkg::lane_cmd_t          cmd_i,
  input  logic                              cmd_valid_i,
  output logic                              done_o,
  output logic [vec_isa_pkg::ElemWidth-1:0] partial_o
);

  localparam int unsigned EW       = vec_isa_pkg::ElemWidth;
  localparam int unsigned CntWidth = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1;

  typedef logic [EW-1:0] elem_t;

  // Element k of this lane is global element k * NrLanes + LaneId
  elem_t                    vrf_q [vec_isa_pkg::NrVRegs][ElemsPerLane];
  vec_uarch_pkg::lane_cmd_t cmd_q;
  logic                     busy_q;
  logic [CntWidth-1:0]      cnt_q;
  elem_t                    acc_q;
  elem_t                    op_a;
  elem_t                    op_b;
  elem_t                    result;
  elem_t                    sum_term;
  logic                     last;
  logic                     wr_en;

  //////////////////////////////////////////////////////////////////////
  // Element ALU
  //////////////////////////////////////////////////////////////////////

  assign op_a = vrf_q[cmd_q.vs2][cnt_q];
  assign op_b = cmd_q.use_scalar ? cmd_q.scalar : vrf_q[cmd_q.vs1][cnt_q];

  always_comb begin
    case (cmd_q.op)
      vec_uarch_pkg::LANE_SPLAT: result = cmd_q.scalar;
      vec_uarch_pkg::LANE_INDEX: result = elem_t'(cnt_q) * elem_t'(NrLanes) + elem_t'(LaneId);
      vec_uarch_pkg::LANE_ADD:   result = op_a + op_b;
      vec_uarch_pkg::LANE_SUB:   result = op_a - op_b;
      vec_uarch_pkg::LANE_AND:   result = op_a & op_b;
      vec_uarch_pkg::LANE_OR:    result = op_a | op_b;
      vec_uarch_pkg::LANE_XOR:   result = op_a ^ op_b;
      default:                   result = '0;
    endcase
  end

  // Reductions write nothing back
  assign sum_term  = (cmd_q.op == vec_uarch_pkg::LANE_SUM) ? op_a : '0;
  assign wr_en     = busy_q && (cmd_q.op != vec_uarch_pkg::LANE_SUM);
  assign last      = (cnt_q == CntWidth'(ElemsPerLane - 1));
  assign done_o    = busy_q && last;
  // Includes the element in flight, so it is complete on done_o
  assign partial_o = acc_q + sum_term;

  //////////////////////////////////////////////////////////////////////
  // Sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (cmd_valid_i) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (busy_q) begin
      busy_q <= !last;
      cnt_q  <= last ? '0 : cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      cmd_q <= cmd_i;
      acc_q <= '0;
    end else if (busy_q) begin
      acc_q <= partial_o;
    end
    if (wr_en) begin
      vrf_q[cmd_q.vd][cnt_q] <= result;
    end
  end

  // Dispatcher must hold off until this lane has finished
  a_no_start_busy : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cmd_valid_i |-> !busy_q)
    else $error("vec_lane: start pulse while busy");

endmodule : vec_lane

`default_nettype wire

/* verilog/vec_result_unit.sv */
// Tracks a single instruction. A result waits in its slot while the response register is held
`timescale 1ns/10ps
`default_nettype none

module vec_result_unit #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  input  vec_uarch_pkg::result_tag_t                     tag_i,
  input  logic                                           tag_valid_i,
  output logic                                           tag_ready_o,
  input  logic                                           lane_done_i,
  input  logic [NrLanes-1:0][vec_isa_pkg::ElemWidth-1:0] lane_partials_i,
  output vec_isa_pkg::vec_resp_t                         resp_o,
  output logic                                           resp_valid_o,
  input  logic                                           resp_ready_i
);

  localparam int unsigned EW = vec_isa_pkg::ElemWidth;

  vec_uarch_pkg::result_tag_t slot_tag_q;
  logic                       slot_valid_q;
  logic                       slot_done_q;
  logic [EW-1:0]              slot_data_q;
  logic [EW-1:0]              lane_sum;
  logic                       tag_accept;
  logic                       resp_load;
  vec_isa_pkg::vec_resp_t     resp_q;
  logic                       resp_valid_q;

  // Seed plus every lane's partial sum, wrapping
  always_comb begin
    lane_sum = slot_tag_q.seed;
    for (int i = 0; i < NrLanes; i++) begin
      lane_sum = lane_sum + lane_partials_i[i];
    end
  end

  assign tag_ready_o  = !slot_valid_q;
  assign tag_accept   = tag_valid_i && tag_ready_o;
  assign resp_load    = slot_valid_q && (slot_tag_q.error || slot_done_q) &&
                        (!resp_valid_q || resp_ready_i);
  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      slot_valid_q <= 1'b0;
      slot_done_q  <= 1'b0;
      resp_valid_q <= 1'b0;
    end else begin
      if (tag_accept) begin
        slot_valid_q <= 1'b1;
        slot_done_q  <= 1'b0;
      end else if (resp_load) begin
        slot_valid_q <= 1'b0;
      end
      if (lane_done_i) begin
        slot_done_q <= 1'b1;
      end
      if (resp_load) begin
        resp_valid_q <= 1'b1;
      end else if (resp_ready_i) begin
        resp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tag_accept) begin
      slot_tag_q <= tag_i;
    end
    if (lane_done_i) begin
      slot_data_q <= slot_tag_q.is_reduction ? lane_sum : '0;
    end
    if (resp_load) begin
      resp_q <= '{
        id:    slot_tag_q.id,
        error: slot_tag_q.error,
        data:  slot_tag_q.error ? '0 : slot_data_q
      };
    end
  end

  // Lanes finish only a legal instruction that is still awaiting its result
  a_done_has_slot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lane_done_i |-> slot_valid_q && !slot_done_q && !slot_tag_q.error)
    else $error("vec_result_unit: lane_done with no pending instruction");

endmodule : vec_result_unit

`default_nettype wire

/* verilog/vec_unit.sv */
// Responses leave in request order. Latency varies with back-pressure and queue fill
`timescale 1ns/10ps
`default_nettype none

module vec_unit #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 2,
  parameter int unsigned QueueDepth   = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Accelerator request channel
  input  vec_isa_pkg::vec_req_t  acc_req_i,
  input  logic                   acc_req_valid_i,
  output logic                   acc_req_ready_o,
  // Accelerator response channel
  output vec_isa_pkg::vec_resp_t acc_resp_o,
  output logic                   acc_resp_valid_o,
  input  logic                   acc_resp_ready_i
);

  localparam int unsigned EW = vec_isa_pkg::ElemWidth;

  vec_isa_pkg::vec_req_t            req;
  logic                             req_valid;
  logic                             req_ready;
  vec_uarch_pkg::lane_cmd_t         lane_cmd;
  logic                             lane_cmd_valid;
  logic [NrLanes-1:0]               lane_done;
  logic [NrLanes-1:0][EW-1:0]       lane_partial;
  vec_uarch_pkg::result_tag_t       tag;
  logic                             tag_valid;
  logic                             tag_ready;
  vec_isa_pkg::vec_resp_t           resp;
  logic                             resp_valid;
  logic                             resp_ready;

  //////////////////////////////////////////////////////////////////////
  // Request path
  //////////////////////////////////////////////////////////////////////

  vec_queue #(
    .payload_t(vec_isa_pkg::vec_req_t),
    .Depth    (QueueDepth            )
  ) i_req_queue (
    .clk_i  (clk_i          ),
    .rst_n_i(rst_n_i        ),
    .data_i (acc_req_i      ),
    .valid_i(acc_req_valid_i),
    .ready_o(acc_req_ready_o),
    .data_o (req            ),
    .valid_o(req_valid      ),
    .ready_i(req_ready      )
  );

  vec_dispatcher i_dispatcher (
    .clk_i           (clk_i         ),
    .rst_n_i         (rst_n_i       ),
    .req_i           (req           ),
    .req_valid_i     (req_valid     ),
    .req_ready_o     (req_ready     ),
    .lane_cmd_o      (lane_cmd      ),
    .lane_cmd_valid_o(lane_cmd_valid),
    .lane_done_i     (lane_done[0]  ),
    .tag_o           (tag           ),
    .tag_valid_o     (tag_valid     ),
    .tag_ready_i     (tag_ready     )
  );

  // Lanes run in lockstep, so lane 0 speaks for all of them
  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .NrLanes     (NrLanes     ),
      .ElemsPerLane(ElemsPerLane),
      .LaneId      (l           )
    ) i_lane (
      .clk_i      (clk_i          ),
      .rst_n_i    (rst_n_i        ),
      .cmd_i      (lane_cmd       ),
      .cmd_valid_i(lane_cmd_valid ),
      .done_o     (lane_done[l]   ),
      .partial_o  (lane_partial[l])
    );
  end : gen_lanes

  //////////////////////////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////////////////////////

  vec_result_unit #(
    .NrLanes(NrLanes)
  ) i_result_unit (
    .clk_i          (clk_i       ),
    .rst_n_i        (rst_n_i     ),
    .tag_i          (tag         ),
    .tag_valid_i    (tag_valid   ),
    .tag_ready_o    (tag_ready   ),
    .lane_done_i    (lane_done[0]),
    .lane_partials_i(lane_partial),
    .resp_o         (resp        ),
    .resp_valid_o   (resp_valid  ),
    .resp_ready_i   (resp_ready  )
  );

  vec_queue #(
    .payload_t(vec_isa_pkg::vec_resp_t),
    .Depth    (QueueDepth             )
  ) i_resp_queue (
    .clk_i  (clk_i           ),
    .rst_n_i(rst_n_i         ),
    .data_i (resp            ),
    .valid_i(resp_valid      ),
    .ready_o(resp_ready      ),
    .data_o (acc_resp_o      ),
    .valid_o(acc_resp_valid_o),
    .ready_i(acc_resp_ready_i)
  );

  // Every lane completes in the same cycle
  a_lockstep : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lane_done == {NrLanes{lane_done[0]}})
    else $error("vec_unit: lanes out of lockstep");

endmodule : vec_unit

`default_nettype wire

/* sim/vec_clk_gen.sv */
// Free-running clock from time zero. Reset is released on a falling edge after ResetCycles
`timescale 1ns/10ps
`default_nettype none

module vec_clk_gen #(
  parameter int unsigned HalfPeriod  = 5,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HalfPeriod) clk_o = ~clk_o;
    end
  end

  // Release away from the rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule : vec_clk_gen

`default_nettype wire

/* sim/vec_unit_tb.sv */
// Needs default DUT parameters. Expected sums are hand-computed for VL = 8 elements
`timescale 1ns/10ps
`default_nettype none

module vec_unit_tb;

  localparam int unsigned EW          = vec_isa_pkg::ElemWidth;
  localparam int unsigned RW          = vec_isa_pkg::VRegIdxWidth;
  localparam int unsigned IW          = vec_isa_pkg::IdWidth;
  localparam int unsigned Timeout     = 200;
  localparam int unsigned QuietCycles = 20;

  typedef struct packed {
    logic [3:0]    opcode;
    logic [RW-1:0] vd;
    logic [RW-1:0] vs1;
    logic [RW-1:0] vs2;
    logic [EW-1:0] rs1;
    logic [IW-1:0] id;
    logic          exp_error;
    logic [EW-1:0] exp_data;
  } test_entry_t;

  logic                   clk;
  logic                   rst_n;
  vec_isa_pkg::vec_req_t  acc_req;
  logic                   acc_req_valid;
  logic                   acc_req_ready;
  vec_isa_pkg::vec_resp_t acc_resp;
  logic                   acc_resp_valid;
  logic                   acc_resp_ready;
  test_entry_t            entries [$];
  string                  names [$];
  int                     seed = 32'hd85b;

  vec_clk_gen u_clk_gen (
    .clk_o  (clk  ),
    .rst_n_o(rst_n)
  );

  vec_unit u_dut (
    .clk_i           (clk           ),
    .rst_n_i         (rst_n         ),
    .acc_req_i       (acc_req       ),
    .acc_req_valid_i (acc_req_valid ),
    .acc_req_ready_o (acc_req_ready ),
    .acc_resp_o      (acc_resp      ),
    .acc_resp_valid_o(acc_resp_valid),
    .acc_resp_ready_i(acc_resp_ready)
  );

  task automatic stop_run();
    $display("Testbench failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input string field,
                             input logic [EW-1:0] expected, input logic [EW-1:0] actual);
    assert (actual === expected) else begin
      $display("Error: %s %s expected 0x%08h actual 0x%08h", name, field, expected, actual);
      stop_run();
    end
  endtask

  // Ids follow table position, wrapping at the tag width
  task automatic add_entry(input string name, input logic [3:0] opcode,
                           input logic [RW-1:0] vd, input logic [RW-1:0] vs1,
                           input logic [RW-1:0] vs2, input logic [EW-1:0] rs1,
                           input logic exp_error, input logic [EW-1:0] exp_data);
    test_entry_t e;
    e = '{opcode: opcode, vd: vd, vs1: vs1, vs2: vs2, rs1: rs1,
          id: IW'(entries.size()), exp_error: exp_error, exp_data: exp_data};
    entries.push_back(e);
    names.push_back(name);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////////////////////////

  task automatic build_table();
    // v1 = 0..7, then 5 + 28
    add_entry("vid_v1",      vec_isa_pkg::VID_V,      3'd1, 3'd0, 3'd0, 32'd0,  1'b0, 32'd0);
    add_entry("sum_vid",     vec_isa_pkg::VREDSUM_VS, 3'd0, 3'd0, 3'd1, 32'd5,  1'b0, 32'd33);
    add_entry("splat3_v2",   vec_isa_pkg::VMV_VX,     3'd2, 3'd0, 3'd0, 32'd3,  1'b0, 32'd0);
    add_entry("vadd_v3",     vec_isa_pkg::VADD_VV,    3'd3, 3'd2, 3'd1, 32'd0,  1'b0, 32'd0);
    add_entry("sum_vadd",    vec_isa_pkg::VREDSUM_VS, 3'd0, 3'd0, 3'd3, 32'd0,  1'b0, 32'd52);
    add_entry("vaddx_v4",    vec_isa_pkg::VADD_VX,    3'd4, 3'd0, 3'd1, 32'd10, 1'b0, 32'd0);
    add_entry("sum_vaddx",   vec_isa_pkg::VREDSUM_VS, 3'd0, 3'd0, 3'd4, 32'd0,  1'b0, 32'd108);
    add_entry("vsub_v5",     vec_isa_pkg::VSUB_VV,    3'd5, 3'd2, 3'd3, 32'd0,  1'b0, 32'd0);
    add_entry("sum_vsub",    vec_isa_pkg::VREDSUM_VS, 3'd0, 3'd0, 3'd5, 32'd0,  1'b0, 32'd28);
    add_entry("splat6_v6",   vec_isa_pkg::VMV_VX,     3'd6, 3'd0, 3'd0, 32'd6,  1'b0, 32'd0);
    add_entry("vand_v7",     vec_isa_pkg::VAND_VV,    3'd7, 3'd6, 3'd1, 32'd0,  1'b0, 32'd0);
    add_entry("sum_vand",    vec_isa_pkg::VREDSUM_VS, 3'd0, 3'd0, 3'd7, 32'd0,  1'b0, 32'd24);
    add_entry("vor_v7",      vec_isa_pkg::VOR_VV,     3'd7, 3'd6, 3'd1, 32'd0,  1'b0, 32'd0);
    add_entry("sum_vor",     vec_isa_pkg::VREDSUM_VS, 3'd0, 3'd0, 3'd7, 32'd0,  1'b0, 32'd52);
    add_entry("vxor_v7",     vec_isa_pkg::VXOR_VV,    3'd7, 3'd6, 3'd1, 32'd0,  1'b0, 32'd0);
    add_entry("sum_vxor",    vec_isa_pkg::VREDSUM_VS, 3'd0, 3'd0, 3'd7, 32'd0,  1'b0, 32'd28);
    // Would change v7 if it reached the lanes
    add_entry("illegal_op",  4'hf,                    3'd7, 3'd7, 3'd7, 32'd0,  1'b1, 32'd0);
    add_entry("sum_after",   vec_isa_pkg::VREDSUM_VS, 3'd0, 3'd0, 3'd7, 32'd0,  1'b0, 32'd28);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Host side of the request and response channels
  //////////////////////////////////////////////////////////////////////

  task automatic drive_requests();
    int unsigned waited;
    foreach (entries[i]) begin
      acc_req = '{opcode: vec_isa_pkg::vec_opcode_e'(entries[i].opcode),
                  vd: entries[i].vd, vs1: entries[i].vs1, vs2: entries[i].vs2,
                  rs1: entries[i].rs1, id: entries[i].id};
      acc_req_valid = 1'b1;
      waited = 0;
      while (!acc_req_ready) begin
        @(negedge clk);
        waited++;
        assert (waited < Timeout) else begin
          $display("Timeout: request %s was never accepted", names[i]);
          stop_run();
        end
      end
      // Transfer happens on the rising edge in between
      @(negedge clk);
    end
    acc_req_valid = 1'b0;
  endtask

  task automatic collect_responses();
    int unsigned idx;
    int unsigned waited;
    idx = 0;
    waited = 0;
    while (idx < entries.size()) begin
      acc_resp_ready = (($random(seed) & 32'h3) != 0);
      if (acc_resp_valid && acc_resp_ready) begin
        check_value(names[idx], "id", EW'(entries[idx].id), EW'(acc_resp.id));
        check_value(names[idx], "error", EW'(entries[idx].exp_error), EW'(acc_resp.error));
        check_value(names[idx], "data", entries[idx].exp_data, acc_resp.data);
        idx++;
        waited = 0;
      end else begin
        waited++;
        assert (waited < Timeout) else begin
          $display("Timeout: no response arrived for %s", names[idx]);
          stop_run();
        end
      end
      @(negedge clk);
    end
    acc_resp_ready = 1'b1;
  endtask

  initial begin
    int unsigned waited;
    acc_req        = '0;
    acc_req_valid  = 1'b0;
    acc_resp_ready = 1'b0;
    build_table();
    waited = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      waited++;
      assert (waited < Timeout) else begin
        $display("Timeout: reset was never released");
        stop_run();
      end
    end
    check_value("reset", "acc_resp_valid_o", 32'd0, EW'(acc_resp_valid));
    check_value("reset", "acc_req_ready_o", 32'd1, EW'(acc_req_ready));
    fork
      drive_requests();
      collect_responses();
    join
    // One response per request, nothing more
    repeat (QuietCycles) begin
      @(negedge clk);
      assert (!acc_resp_valid) else begin
        $display("Unexpected extra response with id %0d", acc_resp.id);
        stop_run();
      end
    end
    $display("Testbench passed");
    $finish;
  end

endmodule : vec_unit_tb

`default_nettype wire

/* sources.f */
verilog/vec_isa_pkg.sv
verilog/vec_uarch_pkg.sv
verilog/vec_queue.sv
verilog/vec_dispatcher.sv
verilog/vec_lane.sv
verilog/vec_result_unit.sv
verilog/vec_unit.sv
sim/vec_clk_gen.sv
sim/vec_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the vec_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module vec_unit_tb -o vec_unit_tb_sim

out=$(./obj_dir/vec_unit_tb_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1
